//--- flist.f
hw/book_pkg.sv
hw/book_slice.sv
hw/book_locate.sv
hw/book_levels.sv
hw/book_side.sv
test/book_side_assertions.sv
test/tb_book_side.sv

//--- hw/book_levels.sv
module book_levels #(
  parameter int P_ENTRIES = book_pkg::ENTRIES_DEFAULT,
  parameter bit P_IS_BID  = 1'b1
) (
  input  logic                               clk,
  input  logic                               i_arst_n,
  // Held command from the input slice
  input  logic                               i_cmd_valid,
  output logic                               o_cmd_ready,
  input  book_pkg::cmd_t                     i_cmd,
  input  book_pkg::key_t                     i_key,
  input  book_pkg::volume_t                  i_volume,
  // Head change toward the output slice
  output logic                               o_notify_valid,
  input  logic                               i_notify_ready,
  output book_pkg::key_t                     o_notify_key,
  output book_pkg::volume_t                  o_notify_volume,
  // Book state
  output logic [$clog2(P_ENTRIES+1)-1:0]     o_level_count,
  output logic                               o_head_valid,
  output book_pkg::key_t                     o_head_key,
  output book_pkg::volume_t                  o_head_volume
);

  import book_pkg::*;

  localparam int CNT_W = $clog2(P_ENTRIES + 1);

  // Registered list
  logic [P_ENTRIES-1:0]    level_valid;
  key_t [P_ENTRIES-1:0]    level_keys;
  volume_t [P_ENTRIES-1:0] level_volumes;
  logic [CNT_W-1:0]        level_count;

  logic op_clr;
  logic op_add;
  logic op_del;
  logic op_rep;
  logic cmd_fire;

  logic [P_ENTRIES-1:0] match;
  logic [P_ENTRIES-1:0] insert;
  logic [P_ENTRIES-1:0] move_down;
  logic                 full;
  logic [P_ENTRIES-1:0] del_mask;

  // Neighbour views of the list
  key_t [P_ENTRIES-1:0]    keys_above;
  key_t [P_ENTRIES-1:0]    keys_below;
  volume_t [P_ENTRIES-1:0] volumes_above;
  volume_t [P_ENTRIES-1:0] volumes_below;
  logic [P_ENTRIES-1:0]    valid_below;

  // Per-level source selects
  logic [P_ENTRIES-1:0] take_cmd;
  logic [P_ENTRIES-1:0] take_volume;
  logic [P_ENTRIES-1:0] take_above;
  logic [P_ENTRIES-1:0] take_below;

  logic [P_ENTRIES-1:0]    valid_nxt;
  key_t [P_ENTRIES-1:0]    keys_nxt;
  volume_t [P_ENTRIES-1:0] volumes_nxt;
  logic [CNT_W-1:0]        count_nxt;

  logic notify_clr;
  logic notify_add;
  logic notify_del;
  logic notify_rep;

  assign op_clr = (i_cmd == CMD_CLEAR);
  assign op_add = (i_cmd == CMD_ADD);
  assign op_del = (i_cmd == CMD_DELETE);
  assign op_rep = (i_cmd == CMD_REPLACE);

  // A command only retires when its notification has somewhere to go
  assign o_cmd_ready = i_notify_ready;
  assign cmd_fire    = i_cmd_valid & i_notify_ready;

  book_locate #(
    .P_ENTRIES (P_ENTRIES),
    .P_IS_BID  (P_IS_BID)
  ) u_locate (
    .i_level_valid (level_valid),
    .i_level_keys  (level_keys),
    .i_key         (i_key),
    .o_match       (match),
    .o_insert      (insert),
    .o_move_down   (move_down),
    .o_full        (full)
  );

  // Matched level and everything behind it close the gap on a delete
  always_comb begin
    del_mask[0] = match[0];
    for (int i = 1; i < P_ENTRIES; i++) begin
      del_mask[i] = del_mask[i-1] | match[i];
    end
  end

  // Element i-1 lands in slot i, element i+1 lands in slot i
  assign keys_above    = level_keys << KEY_W;
  assign keys_below    = level_keys >> KEY_W;
  assign volumes_above = level_volumes << VOLUME_W;
  assign volumes_below = level_volumes >> VOLUME_W;
  assign valid_below   = level_valid >> 1;

  assign take_cmd    = {P_ENTRIES{op_add}} & insert;
  assign take_volume = take_cmd | ({P_ENTRIES{op_rep}} & match);
  // Tail level that moves down drops out of the shifted mask
  assign take_above  = {P_ENTRIES{op_add}} & (move_down << 1);
  assign take_below  = {P_ENTRIES{op_del}} & del_mask;

  always_comb begin
    for (int i = 0; i < P_ENTRIES; i++) begin
      if (take_cmd[i]) begin
        keys_nxt[i] = i_key;
      end else if (take_above[i]) begin
        keys_nxt[i] = keys_above[i];
      end else if (take_below[i]) begin
        keys_nxt[i] = keys_below[i];
      end else begin
        keys_nxt[i] = level_keys[i];
      end
      // Replace writes only the volume
      if (take_volume[i]) begin
        volumes_nxt[i] = i_volume;
      end else if (take_above[i]) begin
        volumes_nxt[i] = volumes_above[i];
      end else if (take_below[i]) begin
        volumes_nxt[i] = volumes_below[i];
      end else begin
        volumes_nxt[i] = level_volumes[i];
      end
    end
  end

  always_comb begin
    if (op_clr) begin
      valid_nxt = '0;
    end else if (op_add) begin
      valid_nxt = level_valid | take_cmd | take_above;
    end else if (op_del) begin
      valid_nxt = (level_valid & ~take_below) | (valid_below & take_below);
    end else begin
      valid_nxt = level_valid;
    end
  end

  // Count saturates on a full add, moves down only on a delete hit
  always_comb begin
    if (op_clr) begin
      count_nxt = '0;
    end else if (op_add && !full) begin
      count_nxt = level_count + 1'b1;
    end else if (op_del && (match != '0)) begin
      count_nxt = level_count - 1'b1;
    end else begin
      count_nxt = level_count;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      level_valid <= '0;
      level_count <= '0;
    end else if (cmd_fire) begin
      level_valid <= valid_nxt;
      level_count <= count_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      level_keys    <= keys_nxt;
      level_volumes <= volumes_nxt;
    end
  end

  // Head-touching cases
  assign notify_clr = op_clr & level_valid[0];
  assign notify_add = op_add & insert[0];
  assign notify_del = op_del & match[0];
  assign notify_rep = op_rep & match[0];

  // Valid follows the held command, independent of downstream ready
  assign o_notify_valid = i_cmd_valid & (notify_clr | notify_add | notify_del | notify_rep);
  assign o_notify_key   = i_key;

  // Removed volume on delete, zero on clear, command volume otherwise
  always_comb begin
    if (notify_del) begin
      o_notify_volume = level_volumes[0];
    end else if (notify_clr) begin
      o_notify_volume = '0;
    end else begin
      o_notify_volume = i_volume;
    end
  end

  assign o_level_count = level_count;
  assign o_head_valid  = level_valid[0];
  assign o_head_key    = level_keys[0];
  assign o_head_volume = level_volumes[0];

endmodule

//--- hw/book_locate.sv
module book_locate #(
  parameter int P_ENTRIES = book_pkg::ENTRIES_DEFAULT,
  parameter bit P_IS_BID  = 1'b1
) (
  // Current levels, index 0 is the best price
  input  logic [P_ENTRIES-1:0]                 i_level_valid,
  input  book_pkg::key_t [P_ENTRIES-1:0]       i_level_keys,
  // Key of the command under decode
  input  book_pkg::key_t                       i_key,
  // One-hot level holding the same key
  output logic [P_ENTRIES-1:0]                 o_match,
  // One-hot slot where a new level goes
  output logic [P_ENTRIES-1:0]                 o_insert,
  // Valid levels that slide one place toward the tail on an add
  output logic [P_ENTRIES-1:0]                 o_move_down,
  output logic                                 o_full
);

  logic [P_ENTRIES-1:0] key_eq;
  logic [P_ENTRIES-1:0] key_better;
  logic [P_ENTRIES-1:0] ranks_ahead;
  logic [P_ENTRIES-1:0] prev_ahead;

  // Per-level comparison against the command key
  for (genvar i = 0; i < P_ENTRIES; i++) begin : g_cmp
    assign key_eq[i] = (i_level_keys[i] == i_key);

    // Bid side ranks higher prices first, ask side lower prices first
    if (P_IS_BID) begin : g_bid
      assign key_better[i] = (i_level_keys[i] > i_key);
    end else begin : g_ask
      assign key_better[i] = (i_level_keys[i] < i_key);
    end
  end

  // Levels that stay in front of the new key
  // Sorted list makes this a run of ones from the head
  assign ranks_ahead = i_level_valid & (key_eq | key_better);

  // Neighbour toward the head, the head itself sees a virtual level in front
  assign prev_ahead = {ranks_ahead[P_ENTRIES-2:0], 1'b1};

  // First level not ahead of the key
  // All zero when the list is full and the key ranks last
  assign o_insert = ~ranks_ahead & prev_ahead;

  // Insert slot and everything valid behind it
  assign o_move_down = i_level_valid & ~ranks_ahead;

  // Keys are unique in the list, so at most one bit is set
  assign o_match = i_level_valid & key_eq;

  assign o_full = &i_level_valid;

endmodule

//--- hw/book_pkg.sv
package book_pkg;

  // Command codes carried on the command stream
  typedef enum logic [1:0] {
    CMD_CLEAR   = 2'd0,
    CMD_ADD     = 2'd1,
    CMD_DELETE  = 2'd2,
    CMD_REPLACE = 2'd3
  } cmd_t;

  // Price key
  localparam int KEY_W = 16;
  typedef logic [KEY_W-1:0] key_t;

  // Quantity at a price level
  localparam int VOLUME_W = 16;
  typedef logic [VOLUME_W-1:0] volume_t;

  // Default depth of the book side
  localparam int ENTRIES_DEFAULT = 8;

  // Command as held in the input register stage
  typedef struct packed {
    cmd_t    cmd;
    key_t    key;
    volume_t volume;
  } cmd_payload_t;

  // Head change as held in the output register stage
  typedef struct packed {
    key_t    key;
    volume_t volume;
  } notify_payload_t;

endpackage

//--- hw/book_side.sv
module book_side #(
  parameter int P_ENTRIES = book_pkg::ENTRIES_DEFAULT,
  parameter bit P_IS_BID  = 1'b1
) (
  input  logic                               clk,
  input  logic                               i_arst_n,
  // Command stream
  input  logic                               i_cmd_valid,
  output logic                               o_cmd_ready,
  input  book_pkg::cmd_t                     i_cmd,
  input  book_pkg::key_t                     i_cmd_key,
  input  book_pkg::volume_t                  i_cmd_volume,
  // Notification stream
  output logic                               o_notify_valid,
  input  logic                               i_notify_ready,
  output book_pkg::key_t                     o_notify_key,
  output book_pkg::volume_t                  o_notify_volume,
  // Book state
  output logic [$clog2(P_ENTRIES+1)-1:0]     o_level_count,
  output logic                               o_head_valid,
  output book_pkg::key_t                     o_head_key,
  output book_pkg::volume_t                  o_head_volume
);

  import book_pkg::*;

  cmd_payload_t    cmd_in;
  cmd_payload_t    cmd_q;
  logic            cmd_q_valid;
  logic            cmd_q_ready;

  notify_payload_t notify_in;
  notify_payload_t notify_q;
  logic            notify_in_valid;
  logic            notify_in_ready;

  assign cmd_in = '{cmd: i_cmd, key: i_cmd_key, volume: i_cmd_volume};

  // Command register stage
  book_slice #(
    .P_PAYLOAD_T (cmd_payload_t)
  ) u_cmd_slice (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (i_cmd_valid),
    .o_ready   (o_cmd_ready),
    .i_payload (cmd_in),
    .o_valid   (cmd_q_valid),
    .i_ready   (cmd_q_ready),
    .o_payload (cmd_q)
  );

  book_levels #(
    .P_ENTRIES (P_ENTRIES),
    .P_IS_BID  (P_IS_BID)
  ) u_levels (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_cmd_valid     (cmd_q_valid),
    .o_cmd_ready     (cmd_q_ready),
    .i_cmd           (cmd_q.cmd),
    .i_key           (cmd_q.key),
    .i_volume        (cmd_q.volume),
    .o_notify_valid  (notify_in_valid),
    .i_notify_ready  (notify_in_ready),
    .o_notify_key    (notify_in.key),
    .o_notify_volume (notify_in.volume),
    .o_level_count   (o_level_count),
    .o_head_valid    (o_head_valid),
    .o_head_key      (o_head_key),
    .o_head_volume   (o_head_volume)
  );

  // Notification register stage
  book_slice #(
    .P_PAYLOAD_T (notify_payload_t)
  ) u_notify_slice (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (notify_in_valid),
    .o_ready   (notify_in_ready),
    .i_payload (notify_in),
    .o_valid   (o_notify_valid),
    .i_ready   (i_notify_ready),
    .o_payload (notify_q)
  );

  assign o_notify_key    = notify_q.key;
  assign o_notify_volume = notify_q.volume;

endmodule

//--- hw/book_slice.sv
module book_slice #(
  parameter type P_PAYLOAD_T = logic
) (
  input  logic       clk,
  input  logic       i_arst_n,
  // Upstream side
  input  logic       i_valid,
  output logic       o_ready,
  input  P_PAYLOAD_T i_payload,
  // Downstream side
  output logic       o_valid,
  input  logic       i_ready,
  output P_PAYLOAD_T o_payload
);

  logic       full;
  P_PAYLOAD_T payload;

  // Room when empty, or when the held item leaves this cycle
  assign o_ready = ~full | i_ready;

  assign o_valid   = full;
  assign o_payload = payload;

  // Occupancy flag
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= 1'b0;
    end else if (o_ready) begin
      full <= i_valid;
    end
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      payload <= i_payload;
    end
  end

endmodule

//--- run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_book_side -Mdir obj_dir -f flist.f

./obj_dir/Vtb_book_side +verilator+error+limit+1000 | tee sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- test/book_side_assertions.sv
module book_side_assertions #(
  parameter int P_ENTRIES = book_pkg::ENTRIES_DEFAULT
) (
  input logic                           clk,
  input logic                           i_arst_n,
  input logic                           i_cmd_ready,
  input logic                           i_notify_valid,
  input logic                           i_notify_ready,
  input book_pkg::key_t                 i_notify_key,
  input book_pkg::volume_t              i_notify_volume,
  input logic [$clog2(P_ENTRIES+1)-1:0] i_level_count,
  input logic                           i_head_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  // Held notification keeps valid and payload until it is taken
  a_notify_hold : assert property (@(posedge clk) disable iff (!i_arst_n)
    i_notify_valid && !i_notify_ready |=>
      i_notify_valid && $stable(i_notify_key) && $stable(i_notify_volume))
  else begin
    $error("notification changed while stalled");
    fail_count++;
  end

  // Level count stays within the depth
  a_count_range : assert property (@(posedge clk) disable iff (!i_arst_n)
    i_level_count <= P_ENTRIES)
  else begin
    $error("level count above depth");
    fail_count++;
  end

  // Head valid exactly when the list holds a level
  a_head_valid : assert property (@(posedge clk) disable iff (!i_arst_n)
    i_head_valid == (i_level_count != 0))
  else begin
    $error("head valid disagrees with level count");
    fail_count++;
  end

  // Streams idle out of reset
  a_reset_state : assert property (@(posedge clk)
    $rose(i_arst_n) |-> !i_notify_valid && i_cmd_ready)
  else begin
    $error("handshake outputs not in reset state");
    fail_count++;
  end

endmodule

//--- test/tb_book_side.sv
module tb_book_side;
  timeunit 1ns;
  timeprecision 100ps;

  import book_pkg::*;

  localparam int ENTRIES = 8;
  localparam bit IS_BID = 1'b1;
  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 16;
  // Commands issued over all tests
  localparam int N_CMDS = 44;
  localparam int WATCHDOG_CYCLES = N_CMDS * 20 + RESET_CYCLES;

  logic                         clk = 1'b0;
  logic                         i_arst_n;
  logic                         i_cmd_valid;
  logic                         o_cmd_ready;
  cmd_t                         i_cmd;
  key_t                         i_cmd_key;
  volume_t                      i_cmd_volume;
  logic                         o_notify_valid;
  logic                         i_notify_ready;
  key_t                         o_notify_key;
  volume_t                      o_notify_volume;
  logic [$clog2(ENTRIES+1)-1:0] o_level_count;
  logic                         o_head_valid;
  key_t                         o_head_key;
  volume_t                      o_head_volume;

  // Model of the list in best-first order
  key_t    model_keys[$];
  volume_t model_vols[$];
  // Notifications still due in arrival order
  key_t    exp_keys[$];
  volume_t exp_vols[$];

  integer seed = 32'hc3f1_8df3;
  int     errors = 0;
  int     checks = 0;
  int     err_base = 0;
  string  test_name = "reset";

  book_side #(
    .P_ENTRIES (ENTRIES),
    .P_IS_BID  (IS_BID)
  ) i_dut (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_cmd_valid     (i_cmd_valid),
    .o_cmd_ready     (o_cmd_ready),
    .i_cmd           (i_cmd),
    .i_cmd_key       (i_cmd_key),
    .i_cmd_volume    (i_cmd_volume),
    .o_notify_valid  (o_notify_valid),
    .i_notify_ready  (i_notify_ready),
    .o_notify_key    (o_notify_key),
    .o_notify_volume (o_notify_volume),
    .o_level_count   (o_level_count),
    .o_head_valid    (o_head_valid),
    .o_head_key      (o_head_key),
    .o_head_volume   (o_head_volume)
  );

  bind book_side book_side_assertions #(
    .P_ENTRIES (P_ENTRIES)
  ) u_assert (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_cmd_ready     (o_cmd_ready),
    .i_notify_valid  (o_notify_valid),
    .i_notify_ready  (i_notify_ready),
    .i_notify_key    (o_notify_key),
    .i_notify_volume (o_notify_volume),
    .i_level_count   (o_level_count),
    .i_head_valid    (o_head_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // True when level key a stays in front of a new key b
  function automatic bit ranks_ahead(input key_t a, input key_t b);
    if (IS_BID) begin
      return a >= b;
    end
    return a <= b;
  endfunction

  function automatic int find_key(input key_t k);
    foreach (model_keys[i]) begin
      if (model_keys[i] == k) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic expect_notify(input key_t k, input volume_t v);
    exp_keys.push_back(k);
    exp_vols.push_back(v);
  endtask

  // Apply one command to the model and queue any head change
  task automatic model_apply(input cmd_t c, input key_t k, input volume_t v);
    int pos;
    pos = find_key(k);
    case (c)
      CMD_CLEAR: begin
        if (model_keys.size() > 0) begin
          expect_notify(k, '0);
        end
        model_keys.delete();
        model_vols.delete();
      end
      CMD_ADD: begin
        pos = 0;
        while (pos < model_keys.size() && ranks_ahead(model_keys[pos], k)) begin
          pos++;
        end
        model_keys.insert(pos, k);
        model_vols.insert(pos, v);
        if (pos == 0) begin
          expect_notify(k, v);
        end
        // Worst level drops off a full list
        if (model_keys.size() > ENTRIES) begin
          void'(model_keys.pop_back());
          void'(model_vols.pop_back());
        end
      end
      CMD_DELETE: begin
        if (pos == 0) begin
          expect_notify(k, model_vols[0]);
        end
        if (pos >= 0) begin
          model_keys.delete(pos);
          model_vols.delete(pos);
        end
      end
      default: begin
        if (pos >= 0) begin
          model_vols[pos] = v;
        end
        if (pos == 0) begin
          expect_notify(k, v);
        end
      end
    endcase
  endtask

  // Starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_cmd(input cmd_t c, input key_t k, input volume_t v);
    i_cmd_valid  = 1'b1;
    i_cmd        = c;
    i_cmd_key    = k;
    i_cmd_volume = v;
    do begin
      @(posedge clk);
    end while (!o_cmd_ready);
    @(negedge clk);
    i_cmd_valid = 1'b0;
  endtask

  task automatic check_state();
    check_val("count", model_keys.size(), o_level_count);
    check_val("head valid", model_keys.size() > 0, o_head_valid);
    if (model_keys.size() > 0) begin
      check_val("head key", model_keys[0], o_head_key);
      check_val("head volume", model_vols[0], o_head_volume);
    end
  endtask

  // State outputs follow one edge after the command is taken
  task automatic run_cmd(input cmd_t c, input key_t k, input volume_t v);
    model_apply(c, k, v);
    send_cmd(c, k, v);
    @(negedge clk);
    check_state();
  endtask

  // Key not currently in the list
  task automatic pick_new_key(output key_t k);
    do begin
      k = key_t'($random(seed));
    end while (find_key(k) >= 0);
  endtask

  task automatic add_random(input int n);
    key_t k;
    repeat (n) begin
      pick_new_key(k);
      run_cmd(CMD_ADD, k, volume_t'($random(seed)));
    end
  endtask

  task automatic drain_notify();
    int waited;
    waited = 0;
    // Give a notification from the last command time to leave the output stage
    do begin
      @(negedge clk);
      waited++;
    end while (exp_keys.size() > 0 && waited < 20);
    if (exp_keys.size() > 0) begin
      errors++;
      $display("%s: %0d expected notifications never arrived", test_name, exp_keys.size());
    end
    exp_keys.delete();
    exp_vols.delete();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base  = errors;
  endtask

  task automatic end_test();
    drain_notify();
    $display("test %s finished with %0d errors", test_name, errors - err_base);
  endtask

  // Wait for the command side to stall before letting notifications flow again
  task automatic hold_then_release();
    int waited;
    waited = 0;
    while (o_cmd_ready && waited < 30) begin
      @(negedge clk);
      waited++;
    end
    if (o_cmd_ready) begin
      errors++;
      $display("%s: command ready never dropped while notifications were held", test_name);
    end
    repeat (6) @(negedge clk);
    i_notify_ready = 1'b1;
  endtask

  // Every taken notification must be the oldest one due
  always @(posedge clk) begin
    if (i_arst_n && o_notify_valid && i_notify_ready) begin
      if (exp_keys.size() == 0) begin
        errors++;
        $display("%s: unexpected notification with key %h", test_name, o_notify_key);
      end else begin
        check_val("notify key", exp_keys.pop_front(), o_notify_key);
        check_val("notify volume", exp_vols.pop_front(), o_notify_volume);
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    key_t k;
    int   idx;
    int   total;
    i_arst_n       = 1'b0;
    i_cmd_valid    = 1'b0;
    i_cmd          = CMD_CLEAR;
    i_cmd_key      = '0;
    i_cmd_volume   = '0;
    i_notify_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);

    start_test("ordered_add");
    add_random(6);
    end_test();

    // More adds than levels followed by deletes down to empty
    start_test("full_list");
    run_cmd(CMD_CLEAR, key_t'($random(seed)), '0);
    add_random(12);
    repeat (ENTRIES) begin
      idx = $unsigned($random(seed)) % model_keys.size();
      run_cmd(CMD_DELETE, model_keys[idx], '0);
    end
    end_test();

    start_test("delete_replace");
    add_random(5);
    run_cmd(CMD_REPLACE, model_keys[0], volume_t'($random(seed)));
    run_cmd(CMD_REPLACE, model_keys[2], volume_t'($random(seed)));
    run_cmd(CMD_DELETE, model_keys[3], '0);
    run_cmd(CMD_DELETE, model_keys[0], '0);
    // Misses leave the list alone
    pick_new_key(k);
    run_cmd(CMD_DELETE, k, '0);
    pick_new_key(k);
    run_cmd(CMD_REPLACE, k, volume_t'($random(seed)));
    end_test();

    start_test("clear");
    run_cmd(CMD_CLEAR, key_t'($random(seed)), '0);
    run_cmd(CMD_CLEAR, key_t'($random(seed)), '0);
    end_test();

    // Rising keys so that each add becomes the new head
    start_test("back_pressure");
    i_notify_ready = 1'b0;
    fork
      begin
        for (int i = 0; i < 4; i++) begin
          k = key_t'(16'h1000 * (i + 1) + ($random(seed) & 255));
          model_apply(CMD_ADD, k, volume_t'(i + 1));
          send_cmd(CMD_ADD, k, volume_t'(i + 1));
        end
      end
      begin
        hold_then_release();
      end
    join
    @(negedge clk);
    check_state();
    end_test();

    total = errors + int'(i_dut.u_assert.fail_count);
    $display("summary: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, i_dut.u_assert.fail_count);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
